//--- compile.f
+incdir+hw
+incdir+test
hw/csi2_rx_pkg.sv
hw/csi2_lane_aligner.sv
hw/csi2_lane_merger.sv
hw/csi2_packet_parser.sv
hw/csi2_raw10_unpacker.sv
hw/csi2_rx_top.sv
test/csi2_rx_tb.sv

//--- test/csi2_rx_tb_tasks.svh
`ifndef CSI2_RX_TB_TASKS_SVH
`define CSI2_RX_TB_TASKS_SVH

// --------------------
// lane driving
// --------------------

// PPI values of one lane in cycle idx of a packet, n bytes per lane
function automatic dphy_lane_t lane_cycle(input int lane, input int idx, input int n);
	dphy_lane_t l;
	l = '0;
	if (idx == 0) begin
		l.rxdatahs = SYNC_BYTE;
		l.rxsynchs = 1'b1;
	end else if (idx >= 1 && idx <= n) begin
		l.rxdatahs = pkt_q[2 * (idx - 1) + lane];
	end
	if (idx >= 0 && idx <= n) begin
		l.rxvalidhs = 1'b1;
		l.rxactivehs = 1'b1;
	end
	return l;
endfunction

// even bytes on lane 0, odd bytes on lane 1, then an idle gap
task automatic send_packet(input int skew);
	int n;
	int c;
	dphy_lane_t l0;
	dphy_lane_t l1;
	n = pkt_q.size() / 2;
	for (c = 0; c <= n + skew + GAP_CYCLES; c++) begin
		l0 = lane_cycle(0, c, n);
		l1 = lane_cycle(1, c - skew, n);
		@(posedge rxbyteclkhs);
		lanes[0] <= l0;
		lanes[1] <= l1;
	end
endtask

// --------------------
// comparison
// --------------------

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		$display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		report_failure();
	end
endtask

`endif

//--- test/csi2_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "csi2_rx_settings.svh"

module csi2_rx_tb;

	import csi2_rx_pkg::*;

	localparam int SEED = 7420;
	localparam int RESET_CYCLES = 8;
	localparam int GAP_CYCLES = 6;
	localparam int WAIT_LIMIT = 200;
	localparam int LINE_BYTES = 20;
	localparam int LINE_PIX = 16;
	localparam logic [7:0] SYNC_BYTE = 8'hB8;
	localparam logic [7:0] ECC_BYTE = 8'h3F;
	localparam logic [7:0] DT_OTHER = 8'h12;

	logic rxbyteclkhs;
	logic arst_n;
	dphy_lane_t [`CSI2_LANE_NUM-1:0] lanes;
	wire pixel_pair_t pixel;
	wire pixel_valid;
	wire frame_end;

	logic [7:0] pkt_q[$];
	pixel_pair_t exp_q[$];
	pixel_pair_t got_q[$];
	logic [`CSI2_PIX_W-1:0] line_pix [LINE_PIX];
	int fe_cnt = 0;
	int unsigned seed_val;

	csi2_rx_top i_dut (
		.rxbyteclkhs(rxbyteclkhs),
		.arst_n_i(arst_n),
		.lanes_i(lanes),
		.pixel_o(pixel),
		.pixel_valid_o(pixel_valid),
		.frame_end_o(frame_end)
	);

	initial begin
		rxbyteclkhs = 1'b0;
		forever #2 rxbyteclkhs = ~rxbyteclkhs;
	end

	// collect pixel pairs and count frame end pulses
	always @(negedge rxbyteclkhs) begin
		if (pixel_valid) begin
			got_q.push_back(pixel);
		end
		if (frame_end) begin
			fe_cnt++;
		end
	end

	task automatic report_failure();
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	`include "csi2_rx_tb_tasks.svh"

	// --------------------
	// packet building
	// --------------------

	task automatic build_header(input logic [7:0] did, input logic [15:0] wc);
		pkt_q.delete();
		pkt_q.push_back(did);
		pkt_q.push_back(wc[7:0]);
		pkt_q.push_back(wc[15:8]);
		pkt_q.push_back(ECC_BYTE);
	endtask

	task automatic add_crc();
		int unsigned r;
		r = $urandom;
		pkt_q.push_back(r[7:0]);
		pkt_q.push_back(r[15:8]);
	endtask

	task automatic new_pixels();
		int unsigned r;
		int i;
		for (i = 0; i < LINE_PIX; i++) begin
			r = $urandom;
			line_pix[i] = r[`CSI2_PIX_W-1:0];
		end
	endtask

	// each RAW10 group holds four high bytes and then the low bit pairs of pixel k at 2k+1..2k
	task automatic load_line(input logic fs);
		int g;
		int k;
		int b;
		pixel_pair_t e;
		build_header(`CSI2_DT_RAW10, LINE_BYTES);
		for (g = 0; g < LINE_PIX / 4; g++) begin
			b = 4 * g;
			for (k = 0; k < 4; k++) begin
				pkt_q.push_back(line_pix[b + k][9:2]);
			end
			pkt_q.push_back({line_pix[b + 3][1:0], line_pix[b + 2][1:0],
				line_pix[b + 1][1:0], line_pix[b][1:0]});
			e = '{pix0: line_pix[b], pix1: line_pix[b + 1],
				frame_start: fs && (g == 0), line_last: 1'b0};
			exp_q.push_back(e);
			e = '{pix0: line_pix[b + 2], pix1: line_pix[b + 3],
				frame_start: 1'b0, line_last: (g == LINE_PIX / 4 - 1)};
			exp_q.push_back(e);
		end
		add_crc();
	endtask

	task automatic send_short(input logic [7:0] did);
		build_header(did, 16'd1);
		send_packet(0);
	endtask

	// --------------------
	// result checking
	// --------------------

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge rxbyteclkhs);
	endtask

	task automatic compare_pixels();
		int t;
		int i;
		pixel_pair_t g;
		pixel_pair_t e;
		t = 0;
		while (got_q.size() < exp_q.size() && t < WAIT_LIMIT) begin
			@(posedge rxbyteclkhs);
			t++;
		end
		if (got_q.size() < exp_q.size()) begin
			$display("timeout: %0d of %0d pixel pairs arrived", got_q.size(), exp_q.size());
			report_failure();
		end
		idle_cycles(10);
		check_value("pixel pair count", got_q.size(), exp_q.size());
		i = 0;
		while (exp_q.size() > 0) begin
			g = got_q.pop_front();
			e = exp_q.pop_front();
			check_value($sformatf("pair %0d pix0", i), g.pix0, e.pix0);
			check_value($sformatf("pair %0d pix1", i), g.pix1, e.pix1);
			check_value($sformatf("pair %0d frame_start", i), g.frame_start, e.frame_start);
			check_value($sformatf("pair %0d line_last", i), g.line_last, e.line_last);
			i++;
		end
	endtask

	// --------------------
	// directed tests
	// --------------------

	task automatic check_reset_quiet();
		repeat (RESET_CYCLES) begin
			@(negedge rxbyteclkhs);
			check_value("pixel_valid_o in reset", pixel_valid, 1'b0);
			check_value("frame_end_o in reset", frame_end, 1'b0);
		end
		@(posedge rxbyteclkhs);
		arst_n <= 1'b1;
		repeat (10) begin
			@(negedge rxbyteclkhs);
			check_value("pixel_valid_o after reset", pixel_valid, 1'b0);
			check_value("frame_end_o after reset", frame_end, 1'b0);
		end
		check_value("pixel pairs while idle", got_q.size(), 0);
	endtask

	task automatic decode_frame_line();
		send_short(`CSI2_DT_FS);
		new_pixels();
		load_line(1'b1);
		send_packet(0);
		compare_pixels();
	endtask

	// previous line again with lane 1 one cycle late
	task automatic decode_skewed_line();
		load_line(1'b0);
		send_packet(1);
		compare_pixels();
	endtask

	task automatic skip_unknown_type();
		int i;
		int unsigned r;
		send_short(`CSI2_DT_FS);
		build_header(DT_OTHER, 16'd10);
		for (i = 0; i < 10; i++) begin
			r = $urandom;
			pkt_q.push_back(r[7:0]);
		end
		add_crc();
		send_packet(0);
		idle_cycles(10);
		check_value("pixel pairs from data type 0x12", got_q.size(), 0);
		new_pixels();
		load_line(1'b1);
		send_packet(0);
		compare_pixels();
	endtask

	task automatic pulse_frame_end();
		int t;
		check_value("frame_end_o pulses before frame end", fe_cnt, 0);
		send_short(`CSI2_DT_FE);
		t = 0;
		while (fe_cnt == 0 && t < WAIT_LIMIT) begin
			@(posedge rxbyteclkhs);
			t++;
		end
		if (fe_cnt == 0) begin
			$display("frame_end_o never pulsed after the frame-end packet");
			report_failure();
		end
		idle_cycles(10);
		check_value("frame_end_o pulses", fe_cnt, 1);
		check_value("pixel pairs from frame end", got_q.size(), 0);
	endtask

	task automatic decode_two_lines();
		send_short(`CSI2_DT_FS);
		new_pixels();
		load_line(1'b1);
		send_packet(0);
		new_pixels();
		load_line(1'b0);
		send_packet(0);
		compare_pixels();
	endtask

	initial begin
		seed_val = $urandom(SEED);
		arst_n = 1'b0;
		lanes = '0;
		check_reset_quiet();
		decode_frame_line();
		decode_skewed_line();
		skip_unknown_type();
		pulse_frame_end();
		decode_two_lines();
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/csi2_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "csi2_rx_settings.svh"

module csi2_rx_top (
	input wire rxbyteclkhs,
	input wire arst_n_i,
	input wire csi2_rx_pkg::dphy_lane_t [`CSI2_LANE_NUM-1:0] lanes_i,
	output wire csi2_rx_pkg::pixel_pair_t pixel_o,
	output wire pixel_valid_o,
	output wire frame_end_o
);

	import csi2_rx_pkg::*;

	wire lane_byte_t [`CSI2_LANE_NUM-1:0] lane_byte;
	wire [`CSI2_LANE_NUM-1:0] lane_valid;
	wire [`CSI2_LANE_NUM-1:0] lane_end;
	wire byte_pair_t pair;
	wire pair_valid;
	wire payload_t payload;
	wire payload_valid;

	// --------------------
	// per-lane framing
	// --------------------

	genvar k;
	generate
		for (k = 0; k < `CSI2_LANE_NUM; k++) begin : g_lane
			csi2_lane_aligner i_aligner (
				.rxbyteclkhs(rxbyteclkhs),
				.arst_n_i(arst_n_i),
				.lane_i(lanes_i[k]),
				.byte_o(lane_byte[k]),
				.byte_valid_o(lane_valid[k]),
				.lane_end_o(lane_end[k])
			);
		end
	endgenerate

	// --------------------
	// packet pipeline
	// --------------------

	csi2_lane_merger i_merger (
		.rxbyteclkhs(rxbyteclkhs),
		.arst_n_i(arst_n_i),
		.lane_byte_i(lane_byte),
		.lane_valid_i(lane_valid),
		.lane_end_i(lane_end),
		.pair_o(pair),
		.pair_valid_o(pair_valid)
	);

	csi2_packet_parser i_parser (
		.rxbyteclkhs(rxbyteclkhs),
		.arst_n_i(arst_n_i),
		.pair_i(pair),
		.pair_valid_i(pair_valid),
		.payload_o(payload),
		.payload_valid_o(payload_valid),
		.frame_end_o(frame_end_o)
	);

	csi2_raw10_unpacker i_unpacker (
		.rxbyteclkhs(rxbyteclkhs),
		.arst_n_i(arst_n_i),
		.payload_i(payload),
		.payload_valid_i(payload_valid),
		.pixel_o(pixel_o),
		.pixel_valid_o(pixel_valid_o)
	);

endmodule

`default_nettype wire

//--- hw/csi2_raw10_unpacker.sv
`timescale 1ns/100ps
`default_nettype none

`include "csi2_rx_settings.svh"

module csi2_raw10_unpacker (
	input wire rxbyteclkhs,
	input wire arst_n_i,
	input wire csi2_rx_pkg::payload_t payload_i,
	input wire payload_valid_i,
	output csi2_rx_pkg::pixel_pair_t pixel_o,
	output logic pixel_valid_o
);

	localparam int BUF_BYTES = 10;
	localparam int GRP_BYTES = 5;

	logic [`CSI2_BYTE_W-1:0] sreg_q [BUF_BYTES];
	logic [`CSI2_BYTE_W-1:0] sreg_d [BUF_BYTES];
	logic [3:0] cnt_q;
	logic [3:0] cnt_d;
	logic [`CSI2_PIX_W-1:0] pix [4];
	logic [`CSI2_PIX_W-1:0] pend_q [2];
	logic grp_done;
	logic fs_now;
	logic fs_pend_q;
	logic pend_v_q;
	logic pend_last_q;

	// --------------------
	// byte collection
	// --------------------

	always_comb begin
		sreg_d = sreg_q;
		cnt_d = cnt_q;
		if (payload_valid_i) begin
			sreg_d[cnt_q] = payload_i.byte0;
			sreg_d[cnt_q + 1] = payload_i.byte1;
			cnt_d = cnt_q + 4'd2;
		end
		grp_done = cnt_d >= GRP_BYTES;
		// byte 4 of the group holds the two low bits of each pixel
		for (int k = 0; k < 4; k++) begin
			pix[k] = {sreg_d[k], sreg_d[4][2*k +: 2]};
		end
		if (grp_done) begin
			for (int k = 0; k < BUF_BYTES - GRP_BYTES; k++) begin
				sreg_d[k] = sreg_d[k + GRP_BYTES];
			end
			cnt_d = cnt_d - 4'(GRP_BYTES);
		end
		if (payload_valid_i && payload_i.last) begin
			cnt_d = '0;
		end
	end

	assign fs_now = fs_pend_q | (payload_valid_i & payload_i.frame_start);

	// --------------------
	// pixel output
	// --------------------

	// first pair goes out at once, second pair on the next cycle
	always_ff @(posedge rxbyteclkhs or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= '0;
			fs_pend_q <= 1'b0;
			pend_v_q <= 1'b0;
			pend_last_q <= 1'b0;
			pixel_o <= '0;
			pixel_valid_o <= 1'b0;
		end else begin
			cnt_q <= cnt_d;
			pixel_valid_o <= grp_done | pend_v_q;
			if (grp_done) begin
				pixel_o <= '{pix0: pix[0], pix1: pix[1], frame_start: fs_now, line_last: 1'b0};
				pend_v_q <= 1'b1;
				pend_last_q <= payload_i.last;
				fs_pend_q <= 1'b0;
			end else begin
				fs_pend_q <= fs_now;
				if (pend_v_q) begin
					pixel_o <= '{pix0: pend_q[0], pix1: pend_q[1], frame_start: 1'b0,
						line_last: pend_last_q};
					pend_v_q <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge rxbyteclkhs) begin
		sreg_q <= sreg_d;
		if (grp_done) begin
			pend_q[0] <= pix[2];
			pend_q[1] <= pix[3];
		end
	end

endmodule

`default_nettype wire

//--- hw/csi2_packet_parser.sv
`timescale 1ns/100ps
`default_nettype none

`include "csi2_rx_settings.svh"

module csi2_packet_parser (
	input wire rxbyteclkhs,
	input wire arst_n_i,
	input wire csi2_rx_pkg::byte_pair_t pair_i,
	input wire pair_valid_i,
	output csi2_rx_pkg::payload_t payload_o,
	output logic payload_valid_o,
	output logic frame_end_o
);

	import csi2_rx_pkg::*;

	localparam logic [5:0] DT_FS = 6'(`CSI2_DT_FS);
	localparam logic [5:0] DT_FE = 6'(`CSI2_DT_FE);
	localparam logic [5:0] DT_RAW10 = 6'(`CSI2_DT_RAW10);
	localparam logic [`CSI2_WC_W-1:0] PAIR_BYTES = `CSI2_LANE_NUM;
	localparam logic [`CSI2_WC_W-1:0] CRC_LEN = `CSI2_CRC_BYTES;

	typedef enum logic [2:0] {
		ST_HDR_LO,
		ST_HDR_HI,
		ST_PAYLOAD,
		ST_CRC,
		ST_IGNORE
	} state_t;

	state_t state_q;
	logic [`CSI2_BYTE_W-1:0] did_q;
	logic [`CSI2_BYTE_W-1:0] wc_lo_q;
	logic [`CSI2_WC_W-1:0] wc_q;
	logic fs_pend_q;
	logic hdr_start;
	pkt_header_u hdr;
	logic is_fs;
	logic is_fe;
	logic is_raw10;

	// a packet start always restarts header capture
	assign hdr_start = pair_i.pkt_start | (state_q == ST_HDR_LO);

	// data id and wc low came with the first pair, ECC is dropped
	assign hdr = {did_q, pair_i.byte0, wc_lo_q, pair_i.byte1};
	assign is_fs = hdr.short_h.did.dt == DT_FS;
	assign is_fe = hdr.short_h.did.dt == DT_FE;
	assign is_raw10 = (hdr.long_h.did.dt == DT_RAW10) && (hdr.long_h.wc != '0);

	always_ff @(posedge rxbyteclkhs or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_HDR_LO;
			wc_q <= '0;
			fs_pend_q <= 1'b0;
			payload_o <= '0;
			payload_valid_o <= 1'b0;
			frame_end_o <= 1'b0;
		end else begin
			payload_valid_o <= 1'b0;
			frame_end_o <= 1'b0;
			if (pair_valid_i) begin
				if (hdr_start) begin
					state_q <= ST_HDR_HI;
				end else begin
					case (state_q)
						ST_HDR_HI: begin
							if (is_fs) begin
								fs_pend_q <= 1'b1;
							end
							frame_end_o <= is_fe;
							if (is_raw10) begin
								wc_q <= hdr.long_h.wc;
								state_q <= ST_PAYLOAD;
							end else if (pair_i.pkt_end || is_fs || is_fe) begin
								state_q <= ST_HDR_LO;
							end else begin
								state_q <= ST_IGNORE;
							end
						end
						ST_PAYLOAD: begin
							payload_o <= '{byte0: pair_i.byte0, byte1: pair_i.byte1,
								frame_start: fs_pend_q, last: wc_q <= PAIR_BYTES};
							payload_valid_o <= 1'b1;
							fs_pend_q <= 1'b0;
							if (wc_q <= PAIR_BYTES) begin
								wc_q <= CRC_LEN;
								state_q <= ST_CRC;
							end else begin
								wc_q <= wc_q - PAIR_BYTES;
							end
						end
						ST_CRC: begin
							if (wc_q <= PAIR_BYTES) begin
								state_q <= ST_HDR_LO;
							end else begin
								wc_q <= wc_q - PAIR_BYTES;
							end
						end
						// unsupported long packet, skip to its end
						default: begin
							if (pair_i.pkt_end) begin
								state_q <= ST_HDR_LO;
							end
						end
					endcase
				end
			end
		end
	end

	always_ff @(posedge rxbyteclkhs) begin
		if (pair_valid_i && hdr_start) begin
			did_q <= pair_i.byte0;
			wc_lo_q <= pair_i.byte1;
		end
	end

endmodule

`default_nettype wire

//--- hw/csi2_lane_merger.sv
`timescale 1ns/100ps
`default_nettype none

`include "csi2_rx_settings.svh"

module csi2_lane_merger (
	input wire rxbyteclkhs,
	input wire arst_n_i,
	input wire csi2_rx_pkg::lane_byte_t [`CSI2_LANE_NUM-1:0] lane_byte_i,
	input wire [`CSI2_LANE_NUM-1:0] lane_valid_i,
	input wire [`CSI2_LANE_NUM-1:0] lane_end_i,
	output csi2_rx_pkg::byte_pair_t pair_o,
	output logic pair_valid_o
);

	import csi2_rx_pkg::*;

	lane_byte_t [`CSI2_LANE_NUM-1:0] hold_q;
	lane_byte_t [`CSI2_LANE_NUM-1:0] cur;
	logic [`CSI2_LANE_NUM-1:0] hold_v_q;
	logic [`CSI2_LANE_NUM-1:0] avail;
	logic [`CSI2_LANE_NUM-1:0] end_q;
	byte_pair_t stage_q;
	byte_pair_t pair_new;
	logic stage_v_q;
	logic both;
	logic flush;

	// --------------------
	// deskew
	// --------------------

	// held byte is always older than the one on the input
	always_comb begin
		for (int k = 0; k < `CSI2_LANE_NUM; k++) begin
			avail[k] = hold_v_q[k] | lane_valid_i[k];
			cur[k] = hold_v_q[k] ? hold_q[k] : lane_byte_i[k];
		end
	end

	assign both = &avail;
	assign flush = (&end_q) & ~both;
	assign pair_new = '{byte0: cur[0].data, byte1: cur[1].data,
		pkt_start: cur[0].first, pkt_end: 1'b0};

	// --------------------
	// output staging
	// --------------------

	// one pair stays staged so that the end flag can go out with it
	always_ff @(posedge rxbyteclkhs or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hold_v_q <= '0;
			end_q <= '0;
			stage_v_q <= 1'b0;
			pair_o <= '0;
			pair_valid_o <= 1'b0;
		end else begin
			pair_valid_o <= 1'b0;
			for (int k = 0; k < `CSI2_LANE_NUM; k++) begin
				hold_v_q[k] <= ~flush & lane_valid_i[k] & (hold_v_q[k] | ~both);
			end
			end_q <= flush ? '0 : (end_q | lane_end_i);
			stage_v_q <= both | (stage_v_q & ~flush);
			if ((both || flush) && stage_v_q) begin
				pair_o <= stage_q;
				pair_o.pkt_end <= flush;
				pair_valid_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge rxbyteclkhs) begin
		for (int k = 0; k < `CSI2_LANE_NUM; k++) begin
			if (lane_valid_i[k]) begin
				hold_q[k] <= lane_byte_i[k];
			end
		end
		if (both) begin
			stage_q <= pair_new;
		end
	end

endmodule

`default_nettype wire

//--- hw/csi2_lane_aligner.sv
`timescale 1ns/100ps
`default_nettype none

module csi2_lane_aligner (
	input wire rxbyteclkhs,
	input wire arst_n_i,
	input wire csi2_rx_pkg::dphy_lane_t lane_i,
	output csi2_rx_pkg::lane_byte_t byte_o,
	output logic byte_valid_o,
	output logic lane_end_o
);

	logic in_pkt_q;
	logic first_q;
	logic active_q;
	logic take;

	// the sync cycle only opens the packet, its byte is not forwarded
	assign take = in_pkt_q & lane_i.rxvalidhs & lane_i.rxactivehs & ~lane_i.rxsynchs;

	always_ff @(posedge rxbyteclkhs or negedge arst_n_i) begin
		if (!arst_n_i) begin
			in_pkt_q <= 1'b0;
			first_q <= 1'b0;
			active_q <= 1'b0;
			byte_o <= '0;
			byte_valid_o <= 1'b0;
			lane_end_o <= 1'b0;
		end else begin
			active_q <= lane_i.rxactivehs;
			// falling edge of rxactivehs
			lane_end_o <= active_q & ~lane_i.rxactivehs;
			byte_valid_o <= take;

			if (take) begin
				byte_o.data <= lane_i.rxdatahs;
				byte_o.first <= first_q;
			end

			if (lane_i.rxsynchs) begin
				in_pkt_q <= 1'b1;
				first_q <= 1'b1;
			end else if (!lane_i.rxactivehs) begin
				in_pkt_q <= 1'b0;
			end else if (take) begin
				first_q <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/csi2_rx_pkg.sv
`default_nettype none

`include "csi2_rx_settings.svh"

package csi2_rx_pkg;

	// PPI signals of one data lane
	typedef struct packed {
		logic [`CSI2_BYTE_W-1:0] rxdatahs;
		logic rxvalidhs;
		logic rxactivehs;
		logic rxsynchs;
	} dphy_lane_t;

	typedef struct packed {
		logic [`CSI2_BYTE_W-1:0] data;
		logic first;
	} lane_byte_t;

	// byte0 from lane 0, byte1 from lane 1
	typedef struct packed {
		logic [`CSI2_BYTE_W-1:0] byte0;
		logic [`CSI2_BYTE_W-1:0] byte1;
		logic pkt_start;
		logic pkt_end;
	} byte_pair_t;

	typedef struct packed {
		logic [1:0] vc;
		logic [5:0] dt;
	} data_id_t;

	typedef struct packed {
		data_id_t did;
		logic [`CSI2_WC_W-1:0] wc;
		logic [`CSI2_BYTE_W-1:0] ecc;
	} pkt_long_t;

	typedef struct packed {
		data_id_t did;
		logic [`CSI2_WC_W-1:0] num;
		logic [`CSI2_BYTE_W-1:0] ecc;
	} pkt_short_t;

	// same header word, long or short packet meaning
	typedef union packed {
		pkt_long_t long_h;
		pkt_short_t short_h;
	} pkt_header_u;

	typedef struct packed {
		logic [`CSI2_BYTE_W-1:0] byte0;
		logic [`CSI2_BYTE_W-1:0] byte1;
		logic frame_start;
		logic last;
	} payload_t;

	typedef struct packed {
		logic [`CSI2_PIX_W-1:0] pix0;
		logic [`CSI2_PIX_W-1:0] pix1;
		logic frame_start;
		logic line_last;
	} pixel_pair_t;

endpackage

`default_nettype wire

//--- hw/csi2_rx_settings.svh
`ifndef CSI2_RX_SETTINGS_SVH
`define CSI2_RX_SETTINGS_SVH

// --------------------
// lane geometry
// --------------------

`define CSI2_LANE_NUM 2
`define CSI2_BYTE_W 8
`define CSI2_PIX_W 10
`define CSI2_WC_W 16

// --------------------
// packet data types
// --------------------

`define CSI2_DT_FS 8'h00
`define CSI2_DT_FE 8'h01
`define CSI2_DT_RAW10 8'h2B

// trailing checksum after a long packet payload
`define CSI2_CRC_BYTES 2

`endif
